//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build fft_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f fft_top.f --top-module fft_tb -o fft_sim
	./obj_dir/fft_sim | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- fft_top.f
logic/fft_format_pkg.sv
logic/fft_geometry_pkg.sv
logic/fft_link_if.sv
logic/fft_butterfly.sv
logic/fft_twiddle_generator.sv
logic/fft_stage.sv
logic/fft_top.sv
testbench/fft_tb.sv

//--- logic/fft_butterfly.sv
`timescale 1ns/1ns

module fft_butterfly #(
  parameter fft_format_pkg::shortcut_t shortcut = fft_format_pkg::mult_general
) (
  input  fft_format_pkg::sample_t a_re,
  input  fft_format_pkg::sample_t a_im,
  input  fft_format_pkg::sample_t b_re,
  input  fft_format_pkg::sample_t b_im,
  input  fft_format_pkg::sample_t w_re,
  input  fft_format_pkg::sample_t w_im,
  output fft_format_pkg::sample_t c_re,
  output fft_format_pkg::sample_t c_im,
  output fft_format_pkg::sample_t d_re,
  output fft_format_pkg::sample_t d_im
);

  fft_format_pkg::product_t p_rr;
  fft_format_pkg::product_t p_ii;
  fft_format_pkg::product_t p_ri;
  fft_format_pkg::product_t p_ir;

  fft_format_pkg::sample_t q_rr;
  fft_format_pkg::sample_t q_ii;
  fft_format_pkg::sample_t q_ri;
  fft_format_pkg::sample_t q_ir;

  fft_format_pkg::sample_t t_re;
  fft_format_pkg::sample_t t_im;

  // four real products at full width.
  assign p_rr = fft_format_pkg::product_t'(b_re) * fft_format_pkg::product_t'(w_re);
  assign p_ii = fft_format_pkg::product_t'(b_im) * fft_format_pkg::product_t'(w_im);
  assign p_ri = fft_format_pkg::product_t'(b_re) * fft_format_pkg::product_t'(w_im);
  assign p_ir = fft_format_pkg::product_t'(b_im) * fft_format_pkg::product_t'(w_re);

  // back to sample format, rounding toward minus infinity.
  assign q_rr = fft_format_pkg::sample_t'(p_rr >>> fft_format_pkg::frac_bits);
  assign q_ii = fft_format_pkg::sample_t'(p_ii >>> fft_format_pkg::frac_bits);
  assign q_ri = fft_format_pkg::sample_t'(p_ri >>> fft_format_pkg::frac_bits);
  assign q_ir = fft_format_pkg::sample_t'(p_ir >>> fft_format_pkg::frac_bits);

  // t = b * w.
  always_comb begin
    case (shortcut)
      fft_format_pkg::mult_one: begin
        t_re = b_re;
        t_im = b_im;
      end
      fft_format_pkg::mult_neg_one: begin
        t_re = -b_re;
        t_im = -b_im;
      end
      fft_format_pkg::mult_neg_j: begin
        t_re = b_im;   // (br + j*bi) * -j = bi - j*br.
        t_im = -b_re;
      end
      fft_format_pkg::mult_pos_j: begin
        t_re = -b_im;  // (br + j*bi) * j = -bi + j*br.
        t_im = b_re;
      end
      default: begin
        t_re = q_rr - q_ii;
        t_im = q_ri + q_ir;
      end
    endcase
  end

  // sums wrap, no scaling.
  assign c_re = a_re + t_re;
  assign c_im = a_im + t_im;
  assign d_re = a_re - t_re;
  assign d_im = a_im - t_im;

endmodule

//--- logic/fft_format_pkg.sv
package fft_format_pkg;

  // fixed point layout of one real or imaginary component.
  localparam int sample_width = 32;
  localparam int frac_bits    = 16;  // 1.0 is 32'h0001_0000.

  typedef logic signed [sample_width-1:0]   sample_t;
  typedef logic signed [2*sample_width-1:0] product_t;  // full product, 32 fraction bits.

  // how a butterfly applies its twiddle factor.
  typedef enum logic [2:0] {
    mult_general,  // full complex multiply.
    mult_one,      // w = 1.
    mult_neg_one,  // w = -1.
    mult_neg_j,    // w = -j.
    mult_pos_j     // w = +j.
  } shortcut_t;

endpackage

//--- logic/fft_geometry_pkg.sv
package fft_geometry_pkg;

  localparam int n_points      = 8;
  localparam int n_stages      = 3;             // log2(n_points).
  localparam int n_butterflies = n_points / 2;  // per stage.

  // point index within a block.
  typedef logic [n_stages-1:0] index_t;

  // sin(2*pi*k/8) for k = 0..7, same format as the samples.
  // cosines are read a quarter turn further on.
  localparam fft_format_pkg::sample_t sine_table [n_points] = '{
    32'sh0000_0000,  // 0.
    32'sh0000_b505,  // 0.7071.
    32'sh0001_0000,  // 1.0.
    32'sh0000_b505,  // 0.7071.
    32'sh0000_0000,  // 0.
    32'shffff_4afb,  // -0.7071.
    32'shffff_0000,  // -1.0.
    32'shffff_4afb   // -0.7071.
  };

endpackage

//--- logic/fft_link_if.sv
`timescale 1ns/1ns

// one block of complex samples moving between stages.
interface fft_link_if;

  fft_format_pkg::sample_t re [fft_geometry_pkg::n_points];
  fft_format_pkg::sample_t im [fft_geometry_pkg::n_points];
  logic                    val;
  logic                    rdy;

  modport sender (
    output re,
    output im,
    output val,
    input  rdy
  );

  modport receiver (
    input  re,
    input  im,
    input  val,
    output rdy
  );

endinterface

//--- logic/fft_stage.sv
`timescale 1ns/1ns

module fft_stage #(
  parameter int stage = 0
) (
  input logic         clk,
  input logic         reset,
  fft_link_if.receiver upstream,
  fft_link_if.sender   downstream
);

  typedef enum logic {
    idle,
    full
  } state_t;

  state_t state;
  logic   accept;

  fft_format_pkg::sample_t tw_re  [fft_geometry_pkg::n_butterflies];
  fft_format_pkg::sample_t tw_im  [fft_geometry_pkg::n_butterflies];
  fft_format_pkg::sample_t bf_re  [fft_geometry_pkg::n_points];
  fft_format_pkg::sample_t bf_im  [fft_geometry_pkg::n_points];
  fft_format_pkg::sample_t out_re [fft_geometry_pkg::n_points];
  fft_format_pkg::sample_t out_im [fft_geometry_pkg::n_points];

  fft_twiddle_generator #(
    .stage(stage)
  ) u_twiddle (
    .w_re(tw_re),
    .w_im(tw_im)
  );

  for (genvar b = 0; b < fft_geometry_pkg::n_butterflies; b++) begin : g_bfly
    localparam int span  = 1 << stage;
    localparam int upper = (b / span) * (2 * span) + (b % span);
    localparam int lower = upper + span;  // partner differs in bit "stage".
    localparam int k     = (b % span) * (fft_geometry_pkg::n_points / (2 * span));
    localparam fft_format_pkg::shortcut_t code =
      (k == 0)                           ? fft_format_pkg::mult_one   :
      (k == fft_geometry_pkg::n_points / 4) ? fft_format_pkg::mult_neg_j :
                                           fft_format_pkg::mult_general;

    fft_butterfly #(
      .shortcut(code)
    ) u_bfly (
      .a_re(upstream.re[upper]),
      .a_im(upstream.im[upper]),
      .b_re(upstream.re[lower]),
      .b_im(upstream.im[lower]),
      .w_re(tw_re[b]),
      .w_im(tw_im[b]),
      .c_re(bf_re[upper]),
      .c_im(bf_im[upper]),
      .d_re(bf_re[lower]),
      .d_im(bf_im[lower])
    );
  end

  // take a new block when empty or when the held one leaves this cycle.
  assign upstream.rdy = (state == idle) || downstream.rdy;
  assign accept       = upstream.val && upstream.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else if (accept) begin
      state <= full;
    end else if (downstream.rdy) begin
      state <= idle;  // block handed on, nothing behind it.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_re <= bf_re;
      out_im <= bf_im;
    end
  end

  assign downstream.val = (state == full);
  assign downstream.re  = out_re;
  assign downstream.im  = out_im;

  a_val_after_reset: assert property (@(posedge clk) reset |=> !downstream.val);

  // a held block goes on only together with the one replacing it.
  a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
    upstream.val && upstream.rdy && downstream.val |-> downstream.rdy);

  for (genvar i = 0; i < fft_geometry_pkg::n_points; i++) begin : g_hold_check
    a_hold: assert property (@(posedge clk) disable iff (reset)
      downstream.val && !downstream.rdy |=>
        downstream.val && $stable(downstream.re[i]) && $stable(downstream.im[i]));
  end

endmodule

//--- logic/fft_top.sv
`timescale 1ns/1ns

module fft_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_val,
  output logic                    in_rdy,
  input  fft_format_pkg::sample_t in_re  [fft_geometry_pkg::n_points],
  input  fft_format_pkg::sample_t in_im  [fft_geometry_pkg::n_points],
  output logic                    out_val,
  input  logic                    out_rdy,
  output fft_format_pkg::sample_t out_re [fft_geometry_pkg::n_points],
  output fft_format_pkg::sample_t out_im [fft_geometry_pkg::n_points]
);

  function automatic fft_geometry_pkg::index_t bit_reverse(
    input fft_geometry_pkg::index_t idx
  );
    fft_geometry_pkg::index_t rev;
    for (int j = 0; j < fft_geometry_pkg::n_stages; j++) begin
      rev[j] = idx[fft_geometry_pkg::n_stages-1-j];
    end
    return rev;
  endfunction

  // link s feeds stage s, the last one feeds the output ports.
  fft_link_if link [fft_geometry_pkg::n_stages+1] ();

  // input side, samples land at bit-reversed positions.
  for (genvar i = 0; i < fft_geometry_pkg::n_points; i++) begin : g_reorder
    localparam fft_geometry_pkg::index_t rev =
      bit_reverse(fft_geometry_pkg::index_t'(i));

    assign link[0].re[rev] = in_re[i];
    assign link[0].im[rev] = in_im[i];
  end

  assign link[0].val = in_val;
  assign in_rdy      = link[0].rdy;

  for (genvar s = 0; s < fft_geometry_pkg::n_stages; s++) begin : g_stage
    fft_stage #(
      .stage(s)
    ) u_stage (
      .clk       (clk),
      .reset     (reset),
      .upstream  (link[s].receiver),
      .downstream(link[s+1].sender)
    );
  end

  // output side, already in natural frequency order.
  assign out_val                          = link[fft_geometry_pkg::n_stages].val;
  assign link[fft_geometry_pkg::n_stages].rdy = out_rdy;
  assign out_re                           = link[fft_geometry_pkg::n_stages].re;
  assign out_im                           = link[fft_geometry_pkg::n_stages].im;

endmodule

//--- logic/fft_twiddle_generator.sv
`timescale 1ns/1ns

module fft_twiddle_generator #(
  parameter int stage = 0
) (
  output fft_format_pkg::sample_t w_re [fft_geometry_pkg::n_butterflies],
  output fft_format_pkg::sample_t w_im [fft_geometry_pkg::n_butterflies]
);

  localparam int span = 1 << stage;                          // distinct twiddles here.
  localparam int step = fft_geometry_pkg::n_points / (2 * span);  // table stride.

  if (stage < 0 || stage >= fft_geometry_pkg::n_stages) begin : g_stage_check
    $fatal(1, "fft_twiddle_generator: stage %0d out of range", stage);
  end

  for (genvar b = 0; b < fft_geometry_pkg::n_butterflies; b++) begin : g_twiddle
    localparam fft_geometry_pkg::index_t k =
      fft_geometry_pkg::index_t'((b % span) * step);
    localparam fft_geometry_pkg::index_t k_cos =
      fft_geometry_pkg::index_t'(k + 2);  // quarter turn, wraps at 8.

    // w = cos(2*pi*k/8) - j*sin(2*pi*k/8).
    assign w_re[b] = fft_geometry_pkg::sine_table[k_cos];
    assign w_im[b] = -fft_geometry_pkg::sine_table[k];
  end

endmodule

//--- testbench/fft_input.txt
// four lines per vector: input re, input im, expected re, expected im.
// each line holds points 0 to 7, 32-bit two's complement with 16 fraction bits.
// impulse at 0.
00010000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// constant 1.0.
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00080000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// real cosine at bin 2.
00010000 00000000 ffff0000 00000000 00010000 00000000 ffff0000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00040000 00000000 00000000 00000000 00040000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// impulse at 1.
00000000 00010000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 0000b505 00000000 ffff4afb ffff0000 ffff4afb 00000000 0000b505
00000000 ffff4afb ffff0000 ffff4afb 00000000 0000b505 00010000 0000b505
// complex tone at bin 1, truncation shows in bins 1 and 5.
00010000 0000b505 00000000 ffff4afb ffff0000 ffff4afb 00000000 0000b505
00000000 0000b505 00010000 0000b505 00000000 ffff4afb ffff0000 ffff4afb
00000000 00080001 00000000 00000000 00000000 ffffffff 00000000 00000000
00000000 ffffffff 00000000 00000000 00000000 00000001 00000000 00000000
// complex tone at bin 2.
00010000 00000000 ffff0000 00000000 00010000 00000000 ffff0000 00000000
00000000 00010000 00000000 ffff0000 00000000 00010000 00000000 ffff0000
00000000 00000000 00080000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// complex tone at bin 3.
00010000 ffff4afb 00000000 0000b505 ffff0000 0000b505 00000000 ffff4afb
00000000 0000b505 ffff0000 0000b505 00000000 ffff4afb 00010000 ffff4afb
00000000 00000000 00000000 00080001 00000000 00000000 00000000 ffffffff
00000000 00000000 00000000 ffffffff 00000000 00000000 00000000 00000001
// large constant, bin 0 wraps.
30000000 30000000 30000000 30000000 30000000 30000000 30000000 30000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- testbench/fft_tb.sv
`timescale 1ns/1ns

module fft_tb;

  localparam int n           = fft_geometry_pkg::n_points;
  localparam int block_words = 4 * n;  // in re, in im, out re, out im.
  localparam int max_vectors = 16;
  localparam int wait_limit  = 200;    // cycles.
  localparam int burst_len   = 8;
  localparam int latency     = 3;      // cycles from accept to output.

  logic clk     = 1'b0;
  logic reset   = 1'b1;
  logic in_val  = 1'b0;
  logic in_rdy;
  logic out_val;
  logic out_rdy = 1'b1;

  fft_format_pkg::sample_t in_re   [n];
  fft_format_pkg::sample_t in_im   [n];
  fft_format_pkg::sample_t out_re  [n];
  fft_format_pkg::sample_t out_im  [n];
  fft_format_pkg::sample_t held_re [n];
  fft_format_pkg::sample_t held_im [n];

  logic [31:0] vec_mem [max_vectors*block_words];

  int   n_vectors   = 0;
  int   errors      = 0;
  int   timeouts    = 0;
  int   cycle       = 0;
  int   sent        = 0;
  int   received    = 0;
  int   run_len     = 0;
  int   max_run     = 0;
  logic burst_phase = 1'b0;
  logic stalled     = 1'b0;

  int pending      [$];  // vector index of every block in flight.
  int accept_cycle [$];

  fft_top DUT (
    .clk    (clk),
    .reset  (reset),
    .in_val (in_val),
    .in_rdy (in_rdy),
    .in_re  (in_re),
    .in_im  (in_im),
    .out_val(out_val),
    .out_rdy(out_rdy),
    .out_re (out_re),
    .out_im (out_im)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] fill_word(input int addr);
    return 32'hbad0_0000 ^ addr;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_block(input int v);
    int base;
    base = v * block_words;
    for (int i = 0; i < n; i++) begin
      in_re[i] <= vec_mem[base + i];
      in_im[i] <= vec_mem[base + n + i];
    end
    in_val <= 1'b1;
  endtask

  // holds vector v on the inputs until the DUT takes it.
  task automatic send_block(input int v, input int max_gap);
    int gap;
    int waited;
    gap = $urandom_range(max_gap, 0);
    if (gap > 0) begin
      in_val <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    load_block(v);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!in_rdy && waited < wait_limit);
    if (in_rdy) begin
      pending.push_back(v);
      accept_cycle.push_back(cycle);
      sent++;
    end else begin
      timeouts++;
      $display("timeout at %0t ns: in_rdy stayed low while block %0d was offered", $time, v);
    end
  endtask

  task automatic drain(input string phase);
    int waited;
    waited = 0;
    while (pending.size() != 0 && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      timeouts++;
      $display("timeout at %0t ns: %0d blocks never left the DUT in the %s",
               $time, pending.size(), phase);
    end
  endtask

  // checks every block that leaves the DUT.
  always @(posedge clk) begin : sink
    int v;
    int acc;
    int base;
    if (!reset) begin
      if (stalled) begin
        check_value("out_val while stalled", 32'(out_val), 32'd1);
        for (int i = 0; i < n; i++) begin
          check_value($sformatf("out_re[%0d] while stalled", i), out_re[i], held_re[i]);
          check_value($sformatf("out_im[%0d] while stalled", i), out_im[i], held_im[i]);
        end
      end
      if (out_val && out_rdy) begin
        if (pending.size() == 0) begin
          errors++;
          $display("output block at %0t ns arrived with no block pending", $time);
        end else begin
          v    = pending.pop_front();
          acc  = accept_cycle.pop_front();
          base = v * block_words;
          for (int i = 0; i < n; i++) begin
            check_value($sformatf("out_re[%0d]", i), out_re[i], vec_mem[base + 2*n + i]);
            check_value($sformatf("out_im[%0d]", i), out_im[i], vec_mem[base + 3*n + i]);
          end
          if (burst_phase) begin
            check_value("block latency", 32'(cycle - acc), 32'(latency));
          end
          received++;
        end
      end
      if (burst_phase) begin
        run_len = out_val ? run_len + 1 : 0;
        if (run_len > max_run) max_run = run_len;
      end
      stalled = out_val && !out_rdy;
      held_re = out_re;
      held_im = out_im;
    end
    out_rdy <= burst_phase || ($urandom_range(3, 0) != 0);  // stall about one cycle in four.
  end

  initial begin
    void'($urandom(32'he483_e32b));
    for (int i = 0; i < n; i++) begin
      in_re[i] = '0;
      in_im[i] = '0;
    end
    for (int i = 0; i < max_vectors*block_words; i++) vec_mem[i] = fill_word(i);
    $readmemh("testbench/fft_input.txt", vec_mem);
    while (n_vectors < max_vectors &&
           vec_mem[n_vectors*block_words] !== fill_word(n_vectors*block_words)) begin
      n_vectors++;
    end
    if (n_vectors == 0) begin
      errors++;
      $display("no vectors could be read from testbench/fft_input.txt");
    end

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value("out_val after reset", 32'(out_val), 32'd0);
    check_value("in_rdy after reset", 32'(in_rdy), 32'd1);

    // every vector once with idle cycles and random back-pressure.
    for (int v = 0; v < n_vectors; v++) send_block(v, 3);
    in_val <= 1'b0;
    drain("random phase");
    check_value("blocks received", 32'(received), 32'(n_vectors));
    check_value("blocks sent", 32'(sent), 32'(n_vectors));

    // back to back blocks with out_rdy held high.
    if (n_vectors > 0) begin
      burst_phase <= 1'b1;
      repeat (2) @(posedge clk);
      for (int b = 0; b < burst_len; b++) send_block(b % n_vectors, 0);
      in_val <= 1'b0;
      drain("burst phase");
      check_value("longest out_val run", 32'(max_run), 32'(burst_len));
      burst_phase <= 1'b0;
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
